// ==== fetch_top.f ====
source/fetch_pkg.sv
source/fetch_issue.sv
source/fetch_return.sv
source/fetch_buffer.sv
source/fetch_top.sv
test/tb_clock.sv
test/fetch_top_assert.sv
test/fetch_top_tb.sv

// ==== source/fetch_buffer.sv ====
module fetch_buffer import fetch_pkg::*; #(
    parameter int  BUF_DEPTH = 4,
    localparam int CNT_W     = $clog2(BUF_DEPTH + 1)
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  redirect_t        redirect_i,
    input  logic             push_i,
    input  fetch_pkt_t       push_pkt_i,
    output logic [CNT_W-1:0] level_o,
    output fetch_pkt_t       fetch_pkt_o,
    output logic             fetch_valid_o,
    input  logic             fetch_ready_i
);

    localparam int PTR_W = $clog2(BUF_DEPTH);

    // packet storage, head sits at rd_ptr_q
    fetch_pkt_t       mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] level_q;
    logic             pop;

    // decode handshake
    assign fetch_valid_o = (level_q != '0);
    assign pop           = fetch_valid_o & fetch_ready_i;

    // head entry is only rewritten once it has been popped
    assign fetch_pkt_o   = mem[rd_ptr_q];
    assign level_o       = level_q;

    // credits upstream keep a push away from a full buffer
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else if (redirect_i.valid) begin
            // flush drops every queued packet of the old stream
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // net change of one, or none when both happen
            level_q <= level_q + CNT_W'(push_i) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_pkt_i;
        end
    end

endmodule

// ==== source/fetch_issue.sv ====
module fetch_issue import fetch_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_1000
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  redirect_t redirect_i,
    input  logic      issue_ok_i,
    input  logic      arready_i,
    output axi_ar_t   axi_ar_o,
    output logic      ar_accept_o,
    output addr_t     ar_addr_o
);

    // pc_q is the address of the current or next request
    addr_t pc_q;
    logic  ar_valid_q;
    // redirect seen while an AR was held, applied on its accept
    logic  redir_pend_q;
    addr_t redir_tgt_q;
    logic  accept;

    assign accept = ar_valid_q & arready_i;

    // held request keeps valid and addr until the handshake
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ar_valid_q <= 1'b0;
        end else if (accept) begin
            ar_valid_q <= 1'b0;
        end else if (!ar_valid_q && issue_ok_i) begin
            ar_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q         <= RESET_PC;
            redir_pend_q <= 1'b0;
        end else if (accept) begin
            // newest redirect wins over a pending one
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (redir_pend_q) begin
                pc_q <= redir_tgt_q;
            end else begin
                pc_q <= pc_q + addr_t'(4);
            end
            redir_pend_q <= 1'b0;
        end else if (redirect_i.valid) begin
            // addr must not move under a held AR
            if (ar_valid_q) begin
                redir_pend_q <= 1'b1;
            end else begin
                pc_q <= redirect_i.target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_i.valid) begin
            redir_tgt_q <= redirect_i.target;
        end
    end

    assign axi_ar_o    = '{valid: ar_valid_q, addr: pc_q, prot: AR_PROT_FETCH};
    assign ar_accept_o = accept;
    // address goes to the return side queue on accept
    assign ar_addr_o   = pc_q;

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // one machine word, data and address alike
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] inst_t;

    // rresp codes, slverr and decerr mark a failed fetch
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // arprot for fetches: instruction, secure, privileged
    localparam logic [2:0] AR_PROT_FETCH = 3'b101;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        logic [2:0] prot;
    } axi_ar_t;

    typedef struct packed {
        logic      valid;
        inst_t     data;
        axi_resp_e resp;
    } axi_r_t;

    // branch redirect from the back end
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // one fetched word with its address, handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  err;
    } fetch_pkt_t;

endpackage

// ==== source/fetch_return.sv ====
module fetch_return import fetch_pkg::*; #(
    parameter int  BUF_DEPTH = 4,
    localparam int CNT_W     = $clog2(BUF_DEPTH + 1)
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  redirect_t        redirect_i,
    input  logic             ar_accept_i,
    input  addr_t            ar_addr_i,
    input  logic             axi_ar_valid_i,
    input  axi_r_t           axi_r_i,
    output logic             rready_o,
    input  logic [CNT_W-1:0] buf_level_i,
    output logic             issue_ok_o,
    output logic             push_o,
    output fetch_pkt_t       push_pkt_o
);

    localparam int PTR_W = $clog2(BUF_DEPTH);

    // accepted requests still waiting for their response
    logic [CNT_W-1:0] outstanding_q;
    // responses still to be thrown away after a redirect
    logic [CNT_W-1:0] stale_q;
    logic [CNT_W-1:0] free_slots;
    logic [CNT_W:0]   committed;
    logic             rready_q;
    logic             r_hs;
    logic             live;
    logic             resp_err;

    // addresses of accepted ARs, oldest at the read pointer
    addr_t            aq_mem [BUF_DEPTH];
    logic [PTR_W-1:0] aq_wr_ptr_q;
    logic [PTR_W-1:0] aq_rd_ptr_q;

    // ready comes up once out of reset and stays up
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rready_q <= 1'b0;
        end else begin
            rready_q <= 1'b1;
        end
    end

    assign rready_o = rready_q;
    assign r_hs     = axi_r_i.valid & rready_q;

    // a response in the redirect cycle itself is old stream too
    assign live     = (stale_q == '0) & ~redirect_i.valid;
    assign resp_err = (axi_r_i.resp == SLVERR) || (axi_r_i.resp == DECERR);

    assign push_o     = r_hs & live;
    assign push_pkt_o = '{pc: aq_mem[aq_rd_ptr_q], inst: axi_r_i.data, err: resp_err};

    // credit check, a held AR already owns a slot
    assign free_slots = CNT_W'(BUF_DEPTH) - buf_level_i;
    assign committed  = {1'b0, outstanding_q} + (CNT_W + 1)'(axi_ar_valid_i);
    assign issue_ok_o = {1'b0, free_slots} > committed;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding_q <= '0;
            stale_q       <= '0;
        end else begin
            outstanding_q <= outstanding_q + CNT_W'(ar_accept_i) - CNT_W'(r_hs);
            if (redirect_i.valid) begin
                // everything accepted or held so far turns stale
                stale_q <= outstanding_q + CNT_W'(axi_ar_valid_i) - CNT_W'(r_hs);
            end else if (r_hs && stale_q != '0) begin
                stale_q <= stale_q - 1'b1;
            end
        end
    end

    // every response pops its address, stale or not
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aq_wr_ptr_q <= '0;
            aq_rd_ptr_q <= '0;
        end else begin
            if (ar_accept_i) begin
                aq_wr_ptr_q <= aq_wr_ptr_q + 1'b1;
            end
            if (r_hs) begin
                aq_rd_ptr_q <= aq_rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_accept_i) begin
            aq_mem[aq_wr_ptr_q] <= ar_addr_i;
        end
    end

endmodule

// ==== source/fetch_top.sv ====
module fetch_top import fetch_pkg::*; #(
    parameter int    BUF_DEPTH = 4,
    parameter addr_t RESET_PC  = 32'h0000_1000
) (
    input  logic       clk,
    input  logic       arst_n_i,
    output axi_ar_t    axi_ar_o,
    input  logic       arready_i,
    input  axi_r_t     axi_r_i,
    output logic       rready_o,
    input  redirect_t  redirect_i,
    output fetch_pkt_t fetch_pkt_o,
    output logic       fetch_valid_o,
    input  logic       fetch_ready_i
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    // issue side to return side
    logic             ar_accept;
    addr_t            ar_addr;
    logic             issue_ok;
    // return side to buffer
    logic             push;
    fetch_pkt_t       push_pkt;
    logic [CNT_W-1:0] buf_level;

    // pc and AR channel
    fetch_issue #(
        .RESET_PC(RESET_PC)
    ) fetch_issue_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .redirect_i (redirect_i),
        .issue_ok_i (issue_ok),
        .arready_i  (arready_i),
        .axi_ar_o   (axi_ar_o),
        .ar_accept_o(ar_accept),
        .ar_addr_o  (ar_addr)
    );

    // R channel, stale drop and credits
    fetch_return #(
        .BUF_DEPTH(BUF_DEPTH)
    ) fetch_return_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .redirect_i    (redirect_i),
        .ar_accept_i   (ar_accept),
        .ar_addr_i     (ar_addr),
        .axi_ar_valid_i(axi_ar_o.valid),
        .axi_r_i       (axi_r_i),
        .rready_o      (rready_o),
        .buf_level_i   (buf_level),
        .issue_ok_o    (issue_ok),
        .push_o        (push),
        .push_pkt_o    (push_pkt)
    );

    // packet queue toward decode
    fetch_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) fetch_buffer_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .redirect_i   (redirect_i),
        .push_i       (push),
        .push_pkt_i   (push_pkt),
        .level_o      (buf_level),
        .fetch_pkt_o  (fetch_pkt_o),
        .fetch_valid_o(fetch_valid_o),
        .fetch_ready_i(fetch_ready_i)
    );

endmodule

// ==== test/fetch_top_assert.sv ====
module fetch_top_assert import fetch_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input axi_ar_t    ar_i,
    input logic       arready_i,
    input redirect_t  redirect_i,
    input fetch_pkt_t fetch_pkt_i,
    input logic       fetch_valid_i,
    input logic       fetch_ready_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench monitor
    int unsigned fail_cnt = 0;

    // held AR keeps valid and address until arready
    ar_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ar_i.valid && !arready_i |=> ar_i.valid && $stable(ar_i.addr))
    else begin
        $error("AR valid or address changed while waiting for arready");
        fail_cnt++;
    end

    // stalled packet holds still, a redirect flush excepted
    pkt_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_valid_i && !fetch_ready_i && !redirect_i.valid
        |=> fetch_valid_i && $stable(fetch_pkt_i))
    else begin
        $error("fetch packet changed while decode was stalled");
        fail_cnt++;
    end

    // nothing offered to decode in reset
    no_valid_in_reset: assert property (@(posedge clk) !arst_n_i |-> !fetch_valid_i)
    else begin
        $error("fetch_valid_o high during reset");
        fail_cnt++;
    end

endmodule

bind fetch_top fetch_top_assert fetch_top_assert_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .ar_i         (axi_ar_o),
    .arready_i    (arready_i),
    .redirect_i   (redirect_i),
    .fetch_pkt_i  (fetch_pkt_o),
    .fetch_valid_i(fetch_valid_o),
    .fetch_ready_i(fetch_ready_i)
);

// ==== test/fetch_top_tb.sv ====
module fetch_top_tb import fetch_pkg::*; #(
    parameter int    BUF_DEPTH = 4,
    parameter addr_t RESET_PC  = 32'h0000_1000
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD_NS   = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 200;

    logic       clk;
    logic       arst_n_i;
    axi_ar_t    axi_ar_o;
    logic       arready_i;
    axi_r_t     axi_r_i;
    logic       rready_o;
    redirect_t  redirect_i;
    fetch_pkt_t fetch_pkt_o;
    logic       fetch_valid_o;
    logic       fetch_ready_i;

    // random source for arready, delay and decode ready
    logic [15:0] lfsr_q = 16'd721;
    // accepted requests waiting for their R beat in order
    addr_t       pend_addr_q[$];
    int          pend_due_q[$];
    // next pc decode should see
    addr_t       exp_q[$];
    int          cyc = 0;
    int          ar_accepts = 0;
    int          taken_cnt = 0;
    addr_t       last_pc;
    logic        last_err;
    logic        stall_decode;
    logic        redir_req;
    addr_t       redir_tgt;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) tb_clock_i (.clk_o(clk));

    fetch_top #(.BUF_DEPTH(BUF_DEPTH), .RESET_PC(RESET_PC)) fetch_top_i (.*);

    // galois form with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out;
    endfunction

    // memory contents and the error window
    function automatic fetch_pkt_t expect_pkt(input addr_t pc);
        fetch_pkt_t p;
        p.pc   = pc;
        p.err  = (pc >= 32'h0000_F000) && (pc <= 32'h0000_F0FF);
        p.inst = p.err ? '0 : (pc ^ 32'hC0DE_0000);
        return p;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_pkt(input string name, input fetch_pkt_t got, input fetch_pkt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got pc=%h inst=%h err=%b exp pc=%h inst=%h err=%b",
                $time, name, got.pc, got.inst, got.err, exp.pc, exp.inst, exp.err));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %b exp %b", $time, name, got, exp));
        end
    endtask

    // slave model and decode sink drive the coming edge
    always @(negedge clk) begin : slave_model
        logic       take;
        logic       ar_rdy;
        logic [1:0] delay;
        fetch_pkt_t exp_pkt;
        axi_r_t     beat;
        if (arst_n_i) begin
            cyc++;
            // decode side is checked before any redirect lands
            take = stall_decode ? 1'b0 : lfsr_bit();
            if (fetch_valid_o && take) begin
                exp_pkt = expect_pkt(exp_q.pop_front());
                check_pkt("fetch_pkt_o", fetch_pkt_o, exp_pkt);
                exp_q.push_back(exp_pkt.pc + 32'd4);
                last_pc  = fetch_pkt_o.pc;
                last_err = fetch_pkt_o.err;
                taken_cnt++;
            end
            fetch_ready_i <= take;
            // R beat once its delay is over
            beat = '0;
            if (pend_addr_q.size() > 0 && pend_due_q[0] <= cyc) begin
                check_bit("rready_o", rready_o, 1'b1);
                exp_pkt    = expect_pkt(pend_addr_q.pop_front());
                void'(pend_due_q.pop_front());
                beat.valid = 1'b1;
                beat.data  = exp_pkt.inst;
                beat.resp  = exp_pkt.err ? SLVERR : OKAY;
            end
            axi_r_i <= beat;
            // AR side
            ar_rdy = lfsr_bit();
            if (axi_ar_o.valid && ar_rdy) begin
                // arprot marks an instruction fetch in privileged mode
                check_bit("axi_ar_o.prot[2]", axi_ar_o.prot[2], 1'b1);
                check_bit("axi_ar_o.prot[0]", axi_ar_o.prot[0], 1'b1);
                delay[0] = lfsr_bit();
                delay[1] = lfsr_bit();
                pend_addr_q.push_back(axi_ar_o.addr);
                pend_due_q.push_back(cyc + 1 + int'(delay));
                ar_accepts++;
            end
            arready_i <= ar_rdy;
            // one cycle redirect pulse starts the new stream at target
            if (redir_req) begin
                redirect_i <= '{valid: 1'b1, target: redir_tgt};
                exp_q.delete();
                exp_q.push_back(redir_tgt);
                redir_req = 1'b0;
            end else begin
                redirect_i <= '0;
            end
        end
    end

    // first bound assertion failure ends the run
    always @(negedge clk) begin
        if (fetch_top_i.fetch_top_assert_i.fail_cnt != 0) begin
            abort_run("a bound assertion on the AXI or decode handshake failed");
        end
    end

    task automatic test_reset();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit("fetch_valid_o", fetch_valid_o, 1'b0);
            check_bit("axi_ar_o.valid", axi_ar_o.valid, 1'b0);
            check_bit("rready_o", rready_o, 1'b0);
        end
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_bit("fetch_valid_o", fetch_valid_o, 1'b0);
        check_bit("axi_ar_o.valid", axi_ar_o.valid, 1'b1);
        check_bit("rready_o", rready_o, 1'b1);
        check_addr("axi_ar_o.addr", axi_ar_o.addr, RESET_PC);
    endtask

    task automatic test_sequential();
        wait (taken_cnt >= 40);
        check_addr("last_pc", last_pc, RESET_PC + 32'd156);
    endtask

    task automatic test_backpressure();
        int base;
        @(posedge clk);
        stall_decode = 1'b1;
        // counters settle at the negedge before each edge
        repeat (60) begin
            @(posedge clk);
            if (ar_accepts - taken_cnt > BUF_DEPTH) begin
                abort_run("more requests in flight than the buffer can hold");
            end
        end
        @(negedge clk);
        // buffer full and issue stopped
        check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
        check_bit("axi_ar_o.valid", axi_ar_o.valid, 1'b0);
        @(posedge clk);
        stall_decode = 1'b0;
        base = taken_cnt;
        wait (taken_cnt >= base + 20);
    endtask

    task automatic send_redirect(input addr_t target);
        // wait for something in flight
        do begin
            @(posedge clk);
        end while (pend_addr_q.size() == 0);
        redir_tgt = target;
        redir_req = 1'b1;
        wait (!redir_req);
    endtask

    task automatic test_redirect();
        int base;
        send_redirect(32'h0000_4000);
        base = taken_cnt;
        wait (taken_cnt >= base + 1);
        check_addr("first pc after redirect", last_pc, 32'h0000_4000);
        wait (taken_cnt >= base + 16);
    endtask

    task automatic test_error_response();
        int base;
        send_redirect(32'h0000_F0F8);
        base = taken_cnt;
        wait (taken_cnt >= base + 1);
        check_bit("err at F0F8", last_err, 1'b1);
        wait (taken_cnt >= base + 2);
        check_bit("err at F0FC", last_err, 1'b1);
        wait (taken_cnt >= base + 3);
        check_addr("pc after error window", last_pc, 32'h0000_F100);
        check_bit("err at F100", last_err, 1'b0);
        wait (taken_cnt >= base + 8);
    endtask

    initial begin : main
        arst_n_i      = 1'b0;
        arready_i     = 1'b0;
        axi_r_i       = '0;
        redirect_i    = '0;
        fetch_ready_i = 1'b0;
        stall_decode  = 1'b0;
        redir_req     = 1'b0;
        redir_tgt     = '0;
        exp_q.push_back(RESET_PC);
        test_reset();
        test_sequential();
        test_backpressure();
        test_redirect();
        test_error_response();
        @(negedge clk);
        if (fetch_top_i.fetch_top_assert_i.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // budget scales with the number of tests
    initial begin : watchdog
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS);
        $display("timeout, the tests did not finish within %0d cycles",
            N_TESTS * CYCLES_PER_TEST);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // free running, starts low
    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
